// File: verilog/qspi_pkg.sv
`default_nettype none

package qspi_pkg;

    //////////////////////////////
    // Register map
    //////////////////////////////

    // Byte offsets on the register bus
    localparam logic [5:0] CCR_OFS = 6'd0;
    localparam logic [5:0] ADR_OFS = 6'd4;
    localparam logic [5:0] DR_OFS  = 6'd8;
    localparam logic [5:0] STA_OFS = 6'd40;

    //////////////////////////////
    // Transfer types
    //////////////////////////////

    // Number of lines in the data phase, none skips the phase
    typedef enum logic [1:0] {
        MODE_NONE   = 2'd0,
        MODE_SINGLE = 2'd1,
        MODE_DUAL   = 2'd2,
        MODE_QUAD   = 2'd3
    } qspi_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_CMD   = 3'd1,
        ST_ADDR  = 3'd2,
        ST_DUMMY = 3'd3,
        ST_DATA  = 3'd4
    } qspi_state_e;

    // Command register fields, MSB first
    typedef struct packed {
        logic       start;
        logic [5:0] prescaler;
        logic [2:0] reserved;
        logic       addr_en;
        logic [4:0] size;
        logic [4:0] dummy;
        logic       write;
        qspi_mode_e mode;
        logic [7:0] opcode;
    } qspi_ccr_t;

    // The same word seen per byte lane for masked bus writes
    typedef union packed {
        qspi_ccr_t       fields;
        logic [3:0][7:0] lanes;
    } qspi_ccr_u;

endpackage

`default_nettype wire

// File: verilog/qspi_regfile.sv
`default_nettype none

module qspi_regfile import qspi_pkg::*; (
    input  wire         clk_i,
    input  wire         arst_n_i,
    input  wire         write_i,
    input  wire  [3:0]  be_i,
    input  wire  [5:0]  addr_i,
    input  wire  [31:0] wdata_i,
    input  wire         busy_i,
    input  wire  [4:0]  buf_idx_i,
    input  wire         buf_we_i,
    input  wire  [7:0]  buf_wdata_i,
    output logic [31:0] rdata_o,
    output logic        start_o,
    output logic [7:0]  opcode_o,
    output qspi_mode_e  mode_o,
    output logic        write_o,
    output logic [4:0]  dummy_o,
    output logic [4:0]  size_o,
    output logic        addr_en_o,
    output logic [5:0]  prescaler_o,
    output logic [23:0] addr_o,
    output logic [7:0]  buf_rdata_o
);

    qspi_ccr_u   ccr_q;
    qspi_ccr_u   ccr_wr;
    logic [31:0] adr_q;
    logic [7:0]  buf_q [32];
    logic [31:0] rdata_d;
    logic        start_q;
    logic        locked;
    logic [3:0]  word;
    logic [3:0]  dr_rel;
    logic        dr_hit;
    logic        ccr_we;
    logic        adr_we;
    logic        dr_we;

    // A start already issued counts as busy so the held fields cannot move under the engine
    assign locked = busy_i | start_q;

    assign word   = addr_i[5:2];
    assign dr_rel = word - DR_OFS[5:2];
    // Words below DR wrap around to 14 and 15, so bit 3 rules them out
    assign dr_hit = ~dr_rel[3];

    assign ccr_we = write_i && !locked && (word == CCR_OFS[5:2]);
    assign adr_we = write_i && !locked && (word == ADR_OFS[5:2]);
    assign dr_we  = write_i && !locked && dr_hit;

    //////////////////////////////
    // Command and address
    //////////////////////////////

    always_comb begin
        ccr_wr = ccr_q;
        for (int k = 0; k < 4; k++) begin
            if (be_i[k]) begin
                ccr_wr.lanes[k] = wdata_i[8*k +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ccr_q   <= '0;
            adr_q   <= '0;
            start_q <= 1'b0;
        end else begin
            // The stored start bit is always zero, stale lanes never retrigger
            start_q <= ccr_we && ccr_wr.fields.start;
            if (ccr_we) begin
                ccr_q              <= ccr_wr;
                ccr_q.fields.start <= 1'b0;
            end
            if (adr_we) begin
                for (int k = 0; k < 4; k++) begin
                    if (be_i[k]) begin
                        adr_q[8*k +: 8] <= wdata_i[8*k +: 8];
                    end
                end
            end
        end
    end

    assign start_o     = start_q;
    assign opcode_o    = ccr_q.fields.opcode;
    assign mode_o      = ccr_q.fields.mode;
    assign write_o     = ccr_q.fields.write;
    assign dummy_o     = ccr_q.fields.dummy;
    assign size_o      = ccr_q.fields.size;
    assign addr_en_o   = ccr_q.fields.addr_en;
    assign prescaler_o = ccr_q.fields.prescaler;
    assign addr_o      = adr_q[23:0];

    //////////////////////////////
    // Data buffer
    //////////////////////////////

    // Byte 4*n+k of the buffer sits in lane k of DR word n
    always_ff @(posedge clk_i) begin
        if (buf_we_i) begin
            buf_q[buf_idx_i] <= buf_wdata_i;
        end else if (dr_we) begin
            for (int k = 0; k < 4; k++) begin
                if (be_i[k]) begin
                    buf_q[{dr_rel[2:0], 2'(k)}] <= wdata_i[8*k +: 8];
                end
            end
        end
    end

    assign buf_rdata_o = buf_q[buf_idx_i];

    // Read data is registered, one cycle behind the address
    always_comb begin
        rdata_d = '0;
        if (word == CCR_OFS[5:2]) begin
            rdata_d = ccr_q;
        end else if (word == ADR_OFS[5:2]) begin
            rdata_d = adr_q;
        end else if (word == STA_OFS[5:2]) begin
            rdata_d = {31'b0, locked};
        end else if (dr_hit) begin
            rdata_d = {buf_q[{dr_rel[2:0], 2'd3}], buf_q[{dr_rel[2:0], 2'd2}],
                       buf_q[{dr_rel[2:0], 2'd1}], buf_q[{dr_rel[2:0], 2'd0}]};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= rdata_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/qspi_sclk_gen.sv
`default_nettype none

module qspi_sclk_gen (
    input  wire        clk_i,
    input  wire        arst_n_i,
    input  wire        run_i,
    input  wire  [5:0] prescaler_i,
    output logic       sclk_o,
    output logic       rise_o,
    output logic       fall_o
);

    logic [5:0] cnt_q;
    logic       sclk_q;
    logic       rise_q;
    logic       fall_q;
    logic       tick;

    // Half period ends after prescaler+1 cycles
    assign tick = run_i && (cnt_q == prescaler_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q  <= '0;
            sclk_q <= 1'b0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else if (!run_i) begin
            // Idle low and restart the count so the next transfer gets a full half period
            cnt_q  <= '0;
            sclk_q <= 1'b0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            // Strobes rise together with the new level of sclk
            rise_q <= tick && !sclk_q;
            fall_q <= tick && sclk_q;
            if (tick) begin
                cnt_q  <= '0;
                sclk_q <= ~sclk_q;
            end else begin
                cnt_q <= cnt_q + 6'd1;
            end
        end
    end

    assign sclk_o = sclk_q;
    assign rise_o = rise_q;
    assign fall_o = fall_q;

endmodule

`default_nettype wire

// File: verilog/qspi_engine.sv
`default_nettype none

module qspi_engine import qspi_pkg::*; (
    input  wire         clk_i,
    input  wire         arst_n_i,
    input  wire         start_i,
    input  wire  [7:0]  opcode_i,
    input  var qspi_mode_e mode_i,
    input  wire         write_i,
    input  wire  [4:0]  dummy_i,
    input  wire  [4:0]  size_i,
    input  wire         addr_en_i,
    input  wire  [23:0] addr_i,
    input  wire  [7:0]  buf_rdata_i,
    input  wire         rise_i,
    input  wire         fall_i,
    output logic        busy_o,
    output logic        run_o,
    output logic        cs_n_o,
    output logic [4:0]  buf_idx_o,
    output logic        buf_we_o,
    output logic [7:0]  buf_wdata_o,
    inout  wire  [3:0]  io_io
);

    qspi_state_e state_q;
    qspi_state_e phase_nxt;
    logic [4:0]  cnt_q;
    logic [4:0]  cnt_load;
    logic [4:0]  byte_q;
    logic [4:0]  byte_clks;
    logic        cs_n_q;
    logic [31:0] tx_q;
    logic [7:0]  rx_q;
    logic [7:0]  rx_nxt;
    logic        phase_end;
    logic        last_byte;
    logic        done;
    logic [3:0]  io_out;
    logic [3:0]  io_oe;

    //////////////////////////////
    // Phase sequencing
    //////////////////////////////

    // Serial clocks per data byte, minus one
    always_comb begin
        case (mode_i)
            MODE_DUAL: byte_clks = 5'd3;
            MODE_QUAD: byte_clks = 5'd1;
            default:   byte_clks = 5'd7;
        endcase
    end

    assign last_byte = (byte_q == size_i);
    assign phase_end = (state_q != ST_IDLE) && fall_i && (cnt_q == 5'd0)
                       && ((state_q != ST_DATA) || last_byte);

    // Next phase, skipping the ones that are switched off
    always_comb begin
        if (state_q == ST_CMD && addr_en_i) begin
            phase_nxt = ST_ADDR;
        end else if ((state_q == ST_CMD || state_q == ST_ADDR) && (dummy_i != 5'd0)) begin
            phase_nxt = ST_DUMMY;
        end else if (state_q != ST_DATA && mode_i != MODE_NONE) begin
            phase_nxt = ST_DATA;
        end else begin
            phase_nxt = ST_IDLE;
        end
        case (phase_nxt)
            ST_ADDR:  cnt_load = 5'd23;
            ST_DUMMY: cnt_load = dummy_i - 5'd1;
            ST_DATA:  cnt_load = byte_clks;
            default:  cnt_load = 5'd0;
        endcase
    end

    assign done = phase_end && (phase_nxt == ST_IDLE);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            byte_q  <= '0;
            cs_n_q  <= 1'b1;
        end else if (state_q == ST_IDLE) begin
            if (start_i) begin
                state_q <= ST_CMD;
                cnt_q   <= 5'd7;
                byte_q  <= '0;
                cs_n_q  <= 1'b0;
            end
        end else if (fall_i) begin
            if (cnt_q != 5'd0) begin
                cnt_q <= cnt_q - 5'd1;
            end else if (state_q == ST_DATA && !last_byte) begin
                byte_q <= byte_q + 5'd1;
                cnt_q  <= byte_clks;
            end else begin
                state_q <= phase_nxt;
                cnt_q   <= cnt_load;
                cs_n_q  <= done;
            end
        end
    end

    // Run drops on the last fall so sclk stays low before cs rises
    assign busy_o    = (state_q != ST_IDLE);
    assign run_o     = busy_o && !done;
    assign cs_n_o    = cs_n_q;
    assign buf_idx_o = byte_q;

    //////////////////////////////
    // Shifters
    //////////////////////////////

    // Opcode and address go out of one register, MSB first
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            tx_q <= {opcode_i, addr_i};
        end else if (fall_i) begin
            tx_q <= {tx_q[30:0], 1'b0};
        end
        if (rise_i) begin
            rx_q <= rx_nxt;
        end
    end

    // Lane 0 holds the lowest bit of each group, single line reads come in on io1
    always_comb begin
        case (mode_i)
            MODE_QUAD: rx_nxt = {rx_q[3:0], io_io[3:0]};
            MODE_DUAL: rx_nxt = {rx_q[5:0], io_io[1], io_io[0]};
            default:   rx_nxt = {rx_q[6:0], io_io[1]};
        endcase
    end

    assign buf_we_o    = (state_q == ST_DATA) && !write_i && rise_i && (cnt_q == 5'd0);
    assign buf_wdata_o = rx_nxt;

    //////////////////////////////
    // IO drive
    //////////////////////////////

    always_comb begin
        io_out = {3'b000, tx_q[31]};
        io_oe  = 4'b0000;
        case (state_q)
            ST_CMD, ST_ADDR: io_oe = 4'b0001;
            ST_DATA: begin
                if (write_i) begin
                    // The clock count within the byte selects the bit group
                    case (mode_i)
                        MODE_QUAD: begin
                            io_oe  = 4'b1111;
                            io_out = buf_rdata_i[{cnt_q[0], 2'b00} +: 4];
                        end
                        MODE_DUAL: begin
                            io_oe  = 4'b0011;
                            io_out = {2'b00, buf_rdata_i[{cnt_q[1:0], 1'b0} +: 2]};
                        end
                        default: begin
                            io_oe  = 4'b0001;
                            io_out = {3'b000, buf_rdata_i[cnt_q[2:0]]};
                        end
                    endcase
                end
            end
            default: io_oe = 4'b0000;
        endcase
    end

    for (genvar k = 0; k < 4; k++) begin : g_io
        assign io_io[k] = io_oe[k] ? io_out[k] : 1'bz;
    end

endmodule

`default_nettype wire

// File: verilog/qspi_master.sv
`default_nettype none

module qspi_master import qspi_pkg::*; (
    input  wire         clk_i,
    input  wire         arst_n_i,
    input  wire         write_i,
    input  wire  [3:0]  be_i,
    input  wire  [5:0]  addr_i,
    input  wire  [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        sclk_o,
    output logic        cs_n_o,
    inout  wire  [3:0]  io_io
);

    wire        start;
    wire [7:0]  opcode;
    qspi_mode_e mode;
    wire        xfer_write;
    wire [4:0]  dummy;
    wire [4:0]  size;
    wire        addr_en;
    wire [5:0]  prescaler;
    wire [23:0] addr;
    wire        busy;
    wire        run;
    wire        rise;
    wire        fall;
    wire [4:0]  buf_idx;
    wire        buf_we;
    wire [7:0]  buf_wdata;
    wire [7:0]  buf_rdata;

    qspi_regfile i_regfile (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .write_i     (write_i),
        .be_i        (be_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .busy_i      (busy),
        .buf_idx_i   (buf_idx),
        .buf_we_i    (buf_we),
        .buf_wdata_i (buf_wdata),
        .rdata_o     (rdata_o),
        .start_o     (start),
        .opcode_o    (opcode),
        .mode_o      (mode),
        .write_o     (xfer_write),
        .dummy_o     (dummy),
        .size_o      (size),
        .addr_en_o   (addr_en),
        .prescaler_o (prescaler),
        .addr_o      (addr),
        .buf_rdata_o (buf_rdata)
    );

    qspi_sclk_gen i_sclk_gen (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .run_i       (run),
        .prescaler_i (prescaler),
        .sclk_o      (sclk_o),
        .rise_o      (rise),
        .fall_o      (fall)
    );

    qspi_engine i_engine (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .start_i     (start),
        .opcode_i    (opcode),
        .mode_i      (mode),
        .write_i     (xfer_write),
        .dummy_i     (dummy),
        .size_i      (size),
        .addr_en_i   (addr_en),
        .addr_i      (addr),
        .buf_rdata_i (buf_rdata),
        .rise_i      (rise),
        .fall_i      (fall),
        .busy_o      (busy),
        .run_o       (run),
        .cs_n_o      (cs_n_o),
        .buf_idx_o   (buf_idx),
        .buf_we_o    (buf_we),
        .buf_wdata_o (buf_wdata),
        .io_io       (io_io)
    );

endmodule

`default_nettype wire

// File: sim/qspi_flash_model.sv
`default_nettype none

module qspi_flash_model (
    input  wire         clk_i,
    input  wire         sclk_i,
    input  wire         cs_n_i,
    inout  wire  [3:0]  io_io,
    output logic [7:0]  last_opcode_o,
    output logic [23:0] last_addr_o,
    output logic        wel_o,
    output logic [7:0]  half_period_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [256];
    logic [7:0]  page [32];
    logic [7:0]  op;
    logic [23:0] addr;
    logic [7:0]  acc;
    logic [7:0]  cur;
    logic [3:0]  drv_out = 4'b0000;
    logic [3:0]  drv_oe = 4'b0000;
    logic        sclk_d = 1'b0;
    int          rises;
    int          nbits;
    int          nbytes;
    int          bitpos;
    int          run_len;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'h5A;
        end
        last_opcode_o = 8'h00;
        last_addr_o   = 24'h000000;
        wel_o         = 1'b0;
        half_period_o <= 8'd0;
    end

    // Lines per data clock for the opcodes that have a data phase
    function automatic int lanes_of(logic [7:0] code);
        case (code)
            8'h3B:        return 2;
            8'h6B, 8'h32: return 4;
            default:      return 1;
        endcase
    endfunction

    function automatic int dummy_of(logic [7:0] code);
        return (code == 8'h3B || code == 8'h6B) ? 8 : 0;
    endfunction

    //////////////////////////////
    // Serial protocol in mode 0
    //////////////////////////////

    always @(negedge cs_n_i) begin
        rises  = 0;
        nbits  = 0;
        nbytes = 0;
    end

    // Program data is committed when the transaction ends
    always @(posedge cs_n_i) begin
        drv_oe = 4'b0000;
        for (int i = 0; i < nbytes; i++) begin
            mem[8'(addr + i)] = page[i];
        end
    end

    always @(posedge sclk_i) begin
        if (!cs_n_i) begin
            if (rises < 8) begin
                op = {op[6:0], io_io[0]};
                if (rises == 7) begin
                    last_opcode_o = op;
                    if (op == 8'h06) begin
                        wel_o = 1'b1;
                    end
                end
            end else if (rises < 32) begin
                addr = {addr[22:0], io_io[0]};
                if (rises == 31) begin
                    last_addr_o = addr;
                end
            end else if (op == 8'h02 || op == 8'h32) begin
                if (op == 8'h32) begin
                    acc = {acc[3:0], io_io};
                end else begin
                    acc = {acc[6:0], io_io[0]};
                end
                nbits += lanes_of(op);
                if (nbits == 8 && nbytes < 32) begin
                    page[nbytes] = acc;
                    nbytes++;
                    nbits = 0;
                end
            end
            rises++;
        end
    end

    // Read data changes on the falling edge with the MSB first
    always @(negedge sclk_i) begin
        if (!cs_n_i && (op == 8'h03 || op == 8'h3B || op == 8'h6B)
            && rises >= 32 + dummy_of(op)) begin
            bitpos = (rises - 32 - dummy_of(op)) * lanes_of(op);
            cur    = mem[8'(addr + bitpos / 8)] << (bitpos % 8);
            case (lanes_of(op))
                4: begin
                    drv_out = cur[7:4];
                    drv_oe  = 4'b1111;
                end
                2: begin
                    drv_out = {2'b00, cur[7:6]};
                    drv_oe  = 4'b0011;
                end
                default: begin
                    drv_out = {2'b00, cur[7], 1'b0};
                    drv_oe  = 4'b0010;
                end
            endcase
        end
    end

    for (genvar k = 0; k < 4; k++) begin : g_drv
        assign io_io[k] = drv_oe[k] ? drv_out[k] : 1'bz;
    end

    // Length of the last high phase of sclk in clk_i cycles
    always @(posedge clk_i) begin
        if (sclk_i != sclk_d) begin
            if (!sclk_i) begin
                half_period_o <= 8'(run_len);
            end
            run_len <= 1;
        end else begin
            run_len <= run_len + 1;
        end
        sclk_d <= sclk_i;
    end

endmodule

`default_nettype wire

// File: sim/tb_qspi_master.sv
`default_nettype none

module tb_qspi_master import qspi_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 8;
    localparam int PRESC_FAST  = 1;
    localparam int PRESC_SLOW  = 3;
    // Worst case serial clocks of all transfers at each prescaler
    localparam int FAST_CLOCKS = 8 + 160 + 104 + 72 + 96 + 288;
    localparam int SLOW_CLOCKS = 64;
    localparam int TIMEOUT_NS  = (FAST_CLOCKS * 2 * (PRESC_FAST + 1)
                                 + SLOW_CLOCKS * 2 * (PRESC_SLOW + 1)) * CLK_PERIOD + 20000;
    localparam int POLL_LIMIT  = 2000;

    logic        clk;
    logic        arst_n;
    logic        bus_we;
    logic [3:0]  bus_be;
    logic [5:0]  bus_addr;
    logic [31:0] bus_wdata;
    wire  [31:0] bus_rdata;
    wire         sclk;
    wire         cs_n;
    wire  [3:0]  io;
    wire  [7:0]  last_opcode;
    wire  [23:0] last_addr;
    wire         wel;
    wire  [7:0]  half_period;

    logic [31:0] lfsr;
    logic [7:0]  exp_mem [256];
    logic [7:0]  rd_buf [32];
    logic [7:0]  wr_buf [32];
    int          errors;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pullup (io[0]);
    pullup (io[1]);
    pullup (io[2]);
    pullup (io[3]);

    qspi_master i_dut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .write_i  (bus_we),
        .be_i     (bus_be),
        .addr_i   (bus_addr),
        .wdata_i  (bus_wdata),
        .rdata_o  (bus_rdata),
        .sclk_o   (sclk),
        .cs_n_o   (cs_n),
        .io_io    (io)
    );

    qspi_flash_model i_flash (
        .clk_i         (clk),
        .sclk_i        (sclk),
        .cs_n_i        (cs_n),
        .io_io         (io),
        .last_opcode_o (last_opcode),
        .last_addr_o   (last_addr),
        .wel_o         (wel),
        .half_period_o (half_period)
    );

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_byte(output logic [7:0] b);
        for (int k = 0; k < 8; k++) begin
            b    = {b[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic draw_addr(output logic [23:0] a);
        logic [7:0] b;
        for (int k = 0; k < 3; k++) begin
            draw_byte(b);
            a[8*k +: 8] = b;
        end
    endtask

    function automatic logic [31:0] make_ccr(logic [7:0] op, qspi_mode_e mode, logic wr,
                                             logic [4:0] dummy, logic [4:0] size,
                                             logic addr_en, logic [5:0] presc, logic start);
        qspi_ccr_u c;
        c                  = '0;
        c.fields.opcode    = op;
        c.fields.mode      = mode;
        c.fields.write     = wr;
        c.fields.dummy     = dummy;
        c.fields.size      = size;
        c.fields.addr_en   = addr_en;
        c.fields.prescaler = presc;
        c.fields.start     = start;
        return c;
    endfunction

    // Bus write with byte enables, only enabled lanes take the new data
    function automatic logic [31:0] merge_lanes(logic [31:0] old, logic [31:0] d,
                                                logic [3:0] en);
        logic [31:0] r;
        r = old;
        for (int k = 0; k < 4; k++) begin
            if (en[k]) begin
                r[8*k +: 8] = d[8*k +: 8];
            end
        end
        return r;
    endfunction

    task automatic write_reg(input logic [5:0] a, input logic [31:0] d, input logic [3:0] en);
        @(posedge clk);
        #1;
        bus_we    = 1'b1;
        bus_be    = en;
        bus_addr  = a;
        bus_wdata = d;
        @(posedge clk);
        #1;
        bus_we = 1'b0;
        bus_be = 4'b0000;
    endtask

    // Read data arrives one cycle after the address
    task automatic read_reg(input logic [5:0] a, output logic [31:0] d);
        @(posedge clk);
        #1;
        bus_addr = a;
        @(posedge clk);
        #1;
        d = bus_rdata;
    endtask

    task automatic wait_idle(input string name);
        logic [31:0] sta;
        int          polls;
        polls = 0;
        sta   = 32'd1;
        while (sta[0] && polls < POLL_LIMIT) begin
            read_reg(STA_OFS, sta);
            polls++;
        end
        if (sta[0]) begin
            errors++;
            $display("%s: busy still set after %0d status reads", name, polls);
        end
    endtask

    task automatic clear_buffer();
        for (int n = 0; n < 8; n++) begin
            write_reg(6'(DR_OFS + 4 * n), 32'd0, 4'hf);
        end
    endtask

    task automatic fetch_buffer();
        logic [31:0] w;
        for (int n = 0; n < 8; n++) begin
            read_reg(6'(DR_OFS + 4 * n), w);
            for (int k = 0; k < 4; k++) begin
                rd_buf[4*n+k] = w[8*k +: 8];
            end
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_opcode(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected opcode %h, actual opcode %h", name, exp, act);
        end
    endtask

    task automatic compare_read(input string name, input logic [23:0] a, input int nbytes);
        for (int i = 0; i < nbytes; i++) begin
            check_byte(name, exp_mem[8'(a + i)], rd_buf[i]);
        end
    endtask

    // Runs one receive transfer at the fast prescaler into a cleared buffer
    task automatic read_flash(input logic [7:0] op, input qspi_mode_e mode,
                              input logic [4:0] dummy, input int nbytes, input string name);
        clear_buffer();
        write_reg(CCR_OFS, make_ccr(op, mode, 1'b0, dummy, 5'(nbytes - 1), 1'b1,
                                    6'(PRESC_FAST), 1'b1), 4'hf);
        wait_idle(name);
        fetch_buffer();
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic register_access();
        logic [31:0] w;
        logic [31:0] exp_ccr;
        logic [31:0] exp_adr;
        logic [31:0] exp_dr;
        check_word("reset cs_n", 32'd1, {31'b0, cs_n});
        check_word("reset sclk", 32'd0, {31'b0, sclk});
        read_reg(CCR_OFS, w);
        check_word("reset ccr", 32'd0, w);
        write_reg(CCR_OFS, 32'h3456_789A, 4'b0101);
        write_reg(CCR_OFS, 32'h7ABC_DEF0, 4'b1010);
        exp_ccr = merge_lanes(merge_lanes(32'd0, 32'h3456_789A, 4'b0101),
                              32'h7ABC_DEF0, 4'b1010);
        read_reg(CCR_OFS, w);
        check_word("ccr byte lanes", exp_ccr, w);
        write_reg(ADR_OFS, 32'hA1B2_C3D4, 4'b1111);
        write_reg(ADR_OFS, 32'h0000_FF00, 4'b0010);
        exp_adr = merge_lanes(32'hA1B2_C3D4, 32'h0000_FF00, 4'b0010);
        read_reg(ADR_OFS, w);
        check_word("adr byte lanes", exp_adr, w);
        write_reg(6'(DR_OFS + 12), 32'hCAFE_BABE, 4'b1111);
        write_reg(6'(DR_OFS + 12), 32'h1122_3344, 4'b1001);
        exp_dr = merge_lanes(32'hCAFE_BABE, 32'h1122_3344, 4'b1001);
        read_reg(6'(DR_OFS + 12), w);
        check_word("dr byte lanes", exp_dr, w);
        // A reserved word takes no write and reads zero
        write_reg(6'd44, 32'hFFFF_FFFF, 4'b1111);
        read_reg(6'd44, w);
        check_word("reserved word", 32'd0, w);
        read_reg(STA_OFS, w);
        check_word("idle status", 32'd0, w);
    endtask

    task automatic command_only();
        logic [31:0] w;
        write_reg(CCR_OFS, make_ccr(8'h06, MODE_NONE, 1'b0, 5'd0, 5'd0, 1'b0,
                                    6'(PRESC_FAST), 1'b1), 4'hf);
        read_reg(STA_OFS, w);
        check_word("command busy", 32'd1, w);
        wait_idle("command only");
        check_opcode("command only", 8'h06, last_opcode);
        check_word("write enable flag", 32'd1, {31'b0, wel});
        check_word("command cs_n", 32'd1, {31'b0, cs_n});
    endtask

    task automatic single_read(input logic [23:0] a);
        write_reg(ADR_OFS, {8'h00, a}, 4'hf);
        read_flash(8'h03, MODE_SINGLE, 5'd0, 16, "single read");
        check_opcode("single read", 8'h03, last_opcode);
        check_word("single read address", {8'h00, a}, {8'h00, last_addr});
        compare_read("single read", a, 16);
    endtask

    task automatic dual_quad_read(input logic [23:0] a);
        write_reg(ADR_OFS, {8'h00, a}, 4'hf);
        read_flash(8'h3B, MODE_DUAL, 5'd8, 16, "dual read");
        compare_read("dual read", a, 16);
        read_flash(8'h6B, MODE_QUAD, 5'd8, 16, "quad read");
        check_opcode("quad read", 8'h6B, last_opcode);
        compare_read("quad read", a, 16);
    endtask

    task automatic program_and_verify(input logic [23:0] a);
        logic [31:0] w;
        logic [7:0]  b;
        for (int n = 0; n < 8; n++) begin
            for (int k = 0; k < 4; k++) begin
                draw_byte(b);
                wr_buf[4*n+k] = b;
                w[8*k +: 8]   = b;
            end
            write_reg(6'(DR_OFS + 4 * n), w, 4'hf);
        end
        write_reg(ADR_OFS, {8'h00, a}, 4'hf);
        write_reg(CCR_OFS, make_ccr(8'h32, MODE_QUAD, 1'b1, 5'd0, 5'd31, 1'b1,
                                    6'(PRESC_FAST), 1'b1), 4'hf);
        wait_idle("quad program");
        check_opcode("quad program", 8'h32, last_opcode);
        for (int i = 0; i < 32; i++) begin
            exp_mem[8'(a + i)] = wr_buf[i];
        end
        read_flash(8'h03, MODE_SINGLE, 5'd0, 32, "program read back");
        for (int i = 0; i < 32; i++) begin
            check_byte("program read back", wr_buf[i], rd_buf[i]);
        end
    endtask

    task automatic prescaler_and_guard(input logic [23:0] a);
        logic [31:0] cmd;
        logic [31:0] w;
        cmd = make_ccr(8'h03, MODE_SINGLE, 1'b0, 5'd0, 5'd3, 1'b1, 6'(PRESC_SLOW), 1'b1);
        write_reg(ADR_OFS, {8'h00, a}, 4'hf);
        clear_buffer();
        write_reg(CCR_OFS, cmd, 4'hf);
        // Both writes land while the transfer runs
        write_reg(CCR_OFS, make_ccr(8'h9F, MODE_QUAD, 1'b1, 5'd31, 5'd7, 1'b0, 6'd0, 1'b0),
                  4'hf);
        write_reg(ADR_OFS, 32'hFFFF_FFFF, 4'hf);
        wait_idle("prescaler read");
        read_reg(CCR_OFS, w);
        check_word("ccr write while busy", {1'b0, cmd[30:0]}, w);
        read_reg(ADR_OFS, w);
        check_word("adr write while busy", {8'h00, a}, w);
        check_word("sclk half period", 32'(PRESC_SLOW + 1), {24'b0, half_period});
        fetch_buffer();
        compare_read("prescaler read", a, 4);
    endtask

    //////////////////////////////
    // Run
    //////////////////////////////

    initial begin
        logic [23:0] rd_addr;
        logic [23:0] pg_addr;
        errors    = 0;
        lfsr      = 32'hfa943434;
        clk       = 1'b0;
        arst_n    = 1'b0;
        bus_we    = 1'b0;
        bus_be    = 4'b0000;
        bus_addr  = 6'd0;
        bus_wdata = 32'd0;
        for (int i = 0; i < 256; i++) begin
            exp_mem[i] = 8'(i) ^ 8'h5A;
        end
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        register_access();
        command_only();
        draw_addr(rd_addr);
        single_read(rd_addr);
        dual_quad_read(rd_addr);
        draw_addr(pg_addr);
        program_and_verify(pg_addr);
        prescaler_and_guard(pg_addr + 24'd8);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the serial clocks of all transfers plus bus traffic
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, a transfer never finished", TIMEOUT_NS);
        $display("Errors: %0d", errors + 1);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
verilog/qspi_pkg.sv
verilog/qspi_regfile.sv
verilog/qspi_sclk_gen.sv
verilog/qspi_engine.sv
verilog/qspi_master.sv
sim/qspi_flash_model.sv
sim/tb_qspi_master.sv
